// ==== verilog/hugepage_tx_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// widths, TLP constants, bundles and FSM states shared by the
// hugepage transmit engine; imported by every RTL block that needs them
//////////////////////////////////////////////////////////////////////

package hugepage_tx_pkg;

    localparam int BUF_AW = 9;                          // local buffer depth is 2**BUF_AW qwords

    typedef logic [BUF_AW:0]   buf_addr_t;              // pointer plus wrap bit
    typedef logic [BUF_AW-1:0] buf_rd_addr_t;           // raw buffer address
    typedef logic [4:0]        qword_cnt_t;             // qwords asked for per TLP
    typedef logic [8:0]        tlp_len_t;               // qwords inside one TLP
    typedef logic [31:0]       page_cnt_t;              // qwords written to current page
    typedef logic [63:0]       host_addr_t;             // host byte address

    localparam logic [6:0] MEM_WR64_FMT_TYPE = 7'b1100000;  // MWr, 4DW header
    localparam host_addr_t PAGE_HDR_BYTES    = 64'd128;     // page head holds the qword count
    localparam logic [9:0] CLOSE_LEN_DW      = 10'd2;       // close TLP carries one qword

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [63:0] td;
        logic [7:0]  trem_n;
        logic        tsof_n;
        logic        teof_n;
        logic        tsrc_rdy_n;
    } trn_tx_t;

    typedef struct packed {
        logic       trigger_tlp;                        // data TLP wanted
        logic       change_huge_page;                   // close current page now
        logic       send_last_tlp;                      // one more data TLP, then close
        qword_cnt_t qwords_to_send;
    } tx_req_t;

    //////////////////////////////////////////////////////////////////////
    // state machines
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        idle,
        wait_turn,
        data_hdr,
        data_addr,
        data_payload,
        data_end,
        stall_rewind,
        stall_refill,
        close_hdr,
        close_addr,
        close_count,
        close_end,
        irq_wait
    } tx_state_t;

    typedef enum logic [1:0] {
        slot1_wait,
        slot1_held,
        slot2_wait,
        slot2_held
    } slot_state_t;

endpackage

// ==== verilog/req_sync.sv ====
//////////////////////////////////////////////////////////////////////
// two-flop synchronizer carrying the request bundle from the packet
// clock into the TRN clock
//////////////////////////////////////////////////////////////////////

module req_sync (
    input  logic                     trn_clk,
    input  logic                     reset_n,
    input  hugepage_tx_pkg::tx_req_t req_raw,
    output hugepage_tx_pkg::tx_req_t req_out
);
    import hugepage_tx_pkg::*;

    tx_req_t req_meta;                                  // first stage, may go metastable

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            req_meta <= '0;
            req_out  <= '0;
        end else begin
            req_meta <= req_raw;                        // sample slow domain
            req_out  <= req_meta;                       // settled copy
        end
    end

endmodule

// ==== verilog/ack_stretch.sv ====
//////////////////////////////////////////////////////////////////////
// stretches a one-cycle strobe to three cycles so the slower packet
// domain is sure to see it
//////////////////////////////////////////////////////////////////////

module ack_stretch (
    input  logic trn_clk,
    input  logic reset_n,
    input  logic strobe,
    output logic pulse
);

    logic [1:0] cnt;                                    // 0 idle, 1..3 pulse running

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt <= 2'd0;
        end else if (cnt == 2'd0) begin
            if (strobe) begin
                cnt <= 2'd1;                            // start the pulse
            end
        end else begin
            cnt <= cnt + 2'd1;                          // 3 wraps to 0, strobes ignored meanwhile
        end
    end

    assign pulse = (cnt != 2'd0);

endmodule

// ==== verilog/huge_page_slots.sv ====
//////////////////////////////////////////////////////////////////////
// hands the two host huge pages to the engine in turn and frees them
// in the same order once the engine has closed them
//////////////////////////////////////////////////////////////////////

module huge_page_slots (
    input  logic                        trn_clk,
    input  logic                        reset_n,
    input  hugepage_tx_pkg::host_addr_t huge_page_addr_1,
    input  hugepage_tx_pkg::host_addr_t huge_page_addr_2,
    input  logic                        huge_page_status_1,
    input  logic                        huge_page_status_2,
    input  logic                        page_return,
    output logic                        page_available,
    output hugepage_tx_pkg::host_addr_t current_page_addr,
    output logic                        huge_page_free_1,
    output logic                        huge_page_free_2
);
    import hugepage_tx_pkg::*;

    slot_state_t state;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state             <= slot1_wait;
            page_available    <= 1'b0;
            current_page_addr <= '0;
            huge_page_free_1  <= 1'b0;
            huge_page_free_2  <= 1'b0;
        end else begin
            huge_page_free_1 <= 1'b0;                   // free strobes last one cycle
            huge_page_free_2 <= 1'b0;

            case (state)
                slot1_wait: begin
                    if (huge_page_status_1) begin       // host filled slot 1
                        page_available    <= 1'b1;
                        current_page_addr <= huge_page_addr_1;
                        state             <= slot1_held;
                    end
                end
                slot1_held: begin
                    if (page_return) begin              // engine closed page 1
                        page_available   <= 1'b0;
                        huge_page_free_1 <= 1'b1;
                        state            <= slot2_wait;
                    end
                end
                slot2_wait: begin
                    if (huge_page_status_2) begin
                        page_available    <= 1'b1;
                        current_page_addr <= huge_page_addr_2;
                        state             <= slot2_held;
                    end
                end
                slot2_held: begin
                    if (page_return) begin
                        page_available   <= 1'b0;
                        huge_page_free_2 <= 1'b1;
                        state            <= slot1_wait;   // back to slot 1
                    end
                end
                default: state <= slot1_wait;
            endcase
        end
    end

endmodule

// ==== verilog/tlp_tx_engine.sv ====
//////////////////////////////////////////////////////////////////////
// builds 64-bit MWr TLPs from the local buffer into the current page,
// closes a page with its qword count and raises the interrupt
//////////////////////////////////////////////////////////////////////

module tlp_tx_engine (
    input  logic                          trn_clk,
    input  logic                          reset_n,
    input  hugepage_tx_pkg::tx_req_t      req,
    input  logic                          page_available,
    input  hugepage_tx_pkg::host_addr_t   current_page_addr,
    input  logic                          trn_tdst_rdy_n,
    input  logic [3:0]                    trn_tbuf_av,
    input  logic                          my_turn,
    input  logic [15:0]                   cfg_completer_id,
    input  logic                          cfg_interrupt_rdy_n,
    input  logic [63:0]                   rd_data,
    output hugepage_tx_pkg::buf_rd_addr_t rd_addr,
    output hugepage_tx_pkg::buf_addr_t    commited_rd_address,
    output hugepage_tx_pkg::buf_addr_t    commited_rd_address_to_mac,
    output hugepage_tx_pkg::trn_tx_t      trn_tx,
    output logic                          cfg_interrupt_n,
    output logic                          driving_interface,
    output logic                          tlp_ack_strobe,
    output logic                          page_return,
    output logic                          rd_addr_strobe
);
    import hugepage_tx_pkg::*;

    tx_state_t  state;
    buf_addr_t  rd_addr_ext;                            // read pointer with wrap bit
    buf_addr_t  rd_addr_prev;                           // pointer shown last cycle
    tlp_len_t   qwords_in_tlp;
    tlp_len_t   tlp_qword_cnt;                          // payload words loaded so far
    tlp_len_t   next_qword_cnt;
    host_addr_t host_addr;                              // where the next TLP lands
    page_cnt_t  page_qword_cnt;
    logic [3:0] tlp_tag;
    logic       remember_close;                         // close pending after last TLP
    logic       beat_ok;
    logic       tx_ready;
    logic       load_word;

    // 4DW MWr header, traffic class 0, no digest, both byte enables full
    function automatic logic [63:0] tlp_hdr(input logic [9:0] len_dw, input logic [3:0] tag,
                                            input logic [15:0] req_id);
        return {1'b0, MEM_WR64_FMT_TYPE, 1'b0, 3'b000, 4'b0000, 1'b0, 1'b0, 2'b00, 2'b00,
                len_dw, req_id, 4'b0000, tag, 4'hF, 4'hF};
    endfunction

    // host wants each qword byte reversed
    function automatic logic [63:0] swap64(input logic [63:0] d);
        logic [63:0] s;
        for (int i = 0; i < 8; i++) begin
            s[8*i +: 8] = d[8*(7-i) +: 8];
        end
        return s;
    endfunction

    assign rd_addr        = rd_addr_ext[BUF_AW-1:0];
    assign beat_ok        = !trn_tx.tsrc_rdy_n && !trn_tdst_rdy_n;   // beat taken this cycle
    assign tx_ready       = trn_tbuf_av[1] && !trn_tdst_rdy_n && my_turn;
    assign next_qword_cnt = tlp_qword_cnt + 1'b1;
    assign load_word      = ((state == data_addr || state == data_payload) && beat_ok)
                            || state == stall_refill;

    always_ff @(posedge trn_clk) begin
        rd_addr_prev <= rd_addr_ext;                    // rewind target on a stall
    end

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state                      <= idle;
            trn_tx                     <= '{td: '0, trem_n: '1, tsof_n: 1'b1,
                                            teof_n: 1'b1, tsrc_rdy_n: 1'b1};
            cfg_interrupt_n            <= 1'b1;
            driving_interface          <= 1'b0;
            tlp_ack_strobe             <= 1'b0;
            page_return                <= 1'b0;
            rd_addr_strobe             <= 1'b0;
            rd_addr_ext                <= '0;
            commited_rd_address        <= '0;
            commited_rd_address_to_mac <= '0;
            qwords_in_tlp              <= '0;
            tlp_qword_cnt              <= '0;
            host_addr                  <= '0;
            page_qword_cnt             <= '0;
            tlp_tag                    <= '0;
            remember_close             <= 1'b0;
        end else begin
            tlp_ack_strobe <= 1'b0;                     // strobes default low
            page_return    <= 1'b0;
            rd_addr_strobe <= 1'b0;

            case (state)
                idle: begin
                    driving_interface <= 1'b0;
                    host_addr         <= current_page_addr + PAGE_HDR_BYTES;  // skip page head
                    page_qword_cnt    <= '0;
                    if (page_available) begin
                        state <= wait_turn;
                    end
                end
                wait_turn: begin
                    driving_interface          <= 1'b0;
                    rd_addr_strobe             <= 1'b1;   // tell packet side where we are
                    commited_rd_address_to_mac <= commited_rd_address;
                    rd_addr_ext                <= commited_rd_address;
                    qwords_in_tlp              <= tlp_len_t'(req.qwords_to_send);
                    if (tx_ready && (req.change_huge_page || remember_close)) begin
                        remember_close    <= 1'b0;
                        driving_interface <= 1'b1;
                        trn_tx.td         <= tlp_hdr(CLOSE_LEN_DW, 4'h0, cfg_completer_id);
                        trn_tx.trem_n     <= '0;
                        trn_tx.tsof_n     <= 1'b0;
                        trn_tx.tsrc_rdy_n <= 1'b0;
                        state             <= close_hdr;
                    end else if (tx_ready && (req.send_last_tlp || req.trigger_tlp)) begin
                        remember_close    <= req.send_last_tlp;   // close follows this one
                        driving_interface <= 1'b1;
                        trn_tx.td         <= tlp_hdr(10'({req.qwords_to_send, 1'b0}), tlp_tag,
                                                     cfg_completer_id);
                        trn_tx.trem_n     <= '0;
                        trn_tx.tsof_n     <= 1'b0;
                        trn_tx.tsrc_rdy_n <= 1'b0;
                        state             <= data_hdr;
                    end
                end

                //////////////////////////////////////////////////////////////////////
                // data TLP
                //////////////////////////////////////////////////////////////////////
                data_hdr: begin
                    if (beat_ok) begin
                        trn_tx.tsof_n       <= 1'b1;
                        trn_tx.td           <= host_addr;
                        rd_addr_ext         <= rd_addr_ext + 1'b1;   // first word now in rd_data
                        commited_rd_address <= commited_rd_address + buf_addr_t'(qwords_in_tlp);
                        tlp_qword_cnt       <= '0;
                        tlp_ack_strobe      <= 1'b1;
                        state               <= data_addr;
                    end
                end
                data_addr, data_payload: begin
                    if (!beat_ok) begin
                        rd_addr_ext <= rd_addr_prev;    // re-point at the held word
                        state       <= stall_rewind;
                    end
                end
                stall_rewind: begin
                    if (beat_ok) begin                  // held beat finally taken
                        trn_tx.tsrc_rdy_n <= 1'b1;      // gap while data refills
                        rd_addr_ext       <= rd_addr_ext + 1'b1;
                        state             <= stall_refill;
                    end
                end
                stall_refill: trn_tx.tsrc_rdy_n <= 1'b0;
                data_end: begin
                    if (beat_ok) begin                  // last beat gone, commit the TLP
                        trn_tx            <= '{td: '0, trem_n: '1, tsof_n: 1'b1,
                                               teof_n: 1'b1, tsrc_rdy_n: 1'b1};
                        host_addr         <= host_addr + host_addr_t'({qwords_in_tlp, 3'b000});
                        page_qword_cnt    <= page_qword_cnt + page_cnt_t'(qwords_in_tlp);
                        tlp_tag           <= tlp_tag + 1'b1;
                        state             <= wait_turn;
                    end
                end

                //////////////////////////////////////////////////////////////////////
                // close page and interrupt
                //////////////////////////////////////////////////////////////////////
                close_hdr: begin
                    if (beat_ok) begin
                        trn_tx.tsof_n <= 1'b1;
                        trn_tx.td     <= current_page_addr;   // count goes to page start
                        state         <= close_addr;
                    end
                end
                close_addr: begin
                    if (beat_ok) begin
                        page_return   <= 1'b1;
                        trn_tx.td     <= swap64({32'h0, page_qword_cnt});  // count in upper DW
                        trn_tx.teof_n <= 1'b0;
                        state         <= close_count;
                    end
                end
                close_count: begin
                    if (beat_ok) begin
                        trn_tx <= '{td: '0, trem_n: '1, tsof_n: 1'b1,
                                    teof_n: 1'b1, tsrc_rdy_n: 1'b1};
                        state  <= close_end;
                    end
                end
                close_end: begin
                    cfg_interrupt_n <= 1'b0;
                    state           <= irq_wait;
                end
                irq_wait: begin
                    if (!cfg_interrupt_rdy_n) begin     // core took the interrupt
                        cfg_interrupt_n <= 1'b1;
                        state           <= idle;
                    end
                end
                default: state <= idle;
            endcase

            if (load_word) begin                        // next payload word onto the bus
                trn_tx.td     <= swap64(rd_data);
                rd_addr_ext   <= rd_addr_ext + 1'b1;
                tlp_qword_cnt <= next_qword_cnt;
                if (next_qword_cnt == qwords_in_tlp) begin
                    trn_tx.teof_n <= 1'b0;
                    state         <= data_end;
                end else begin
                    state <= data_payload;
                end
            end
        end
    end

endmodule

// ==== verilog/hugepage_tx_top.sv ====
//////////////////////////////////////////////////////////////////////
// hugepage transmit top, ties synchronizer, ack stretchers, page slots
// and the TLP engine to the TRN interface
//////////////////////////////////////////////////////////////////////

module hugepage_tx_top (
    input  logic                          trn_clk,
    input  logic                          reset_n,
    output hugepage_tx_pkg::trn_tx_t      trn_tx,
    input  logic                          trn_tdst_rdy_n,
    input  logic [3:0]                    trn_tbuf_av,
    input  logic [15:0]                   cfg_completer_id,
    output logic                          cfg_interrupt_n,
    input  logic                          cfg_interrupt_rdy_n,
    input  hugepage_tx_pkg::host_addr_t   huge_page_addr_1,
    input  hugepage_tx_pkg::host_addr_t   huge_page_addr_2,
    input  logic                          huge_page_status_1,
    input  logic                          huge_page_status_2,
    output logic                          huge_page_free_1,
    output logic                          huge_page_free_2,
    input  hugepage_tx_pkg::tx_req_t      req_raw,
    output logic                          trigger_tlp_ack,
    output logic                          change_huge_page_ack,
    output logic                          rd_addr_change,
    output hugepage_tx_pkg::buf_rd_addr_t rd_addr,
    input  logic [63:0]                   rd_data,
    output hugepage_tx_pkg::buf_addr_t    commited_rd_address,
    output hugepage_tx_pkg::buf_addr_t    commited_rd_address_to_mac,
    input  logic                          my_turn,
    output logic                          driving_interface
);
    import hugepage_tx_pkg::*;

    tx_req_t    req_s;                                  // request in TRN domain
    host_addr_t current_page_addr;
    logic       page_available;
    logic       page_return;
    logic       tlp_ack_strobe;
    logic       rd_addr_strobe;

    req_sync u_req_sync (.trn_clk, .reset_n, .req_raw, .req_out(req_s));

    ack_stretch u_tlp_ack  (.trn_clk, .reset_n, .strobe(tlp_ack_strobe), .pulse(trigger_tlp_ack));
    ack_stretch u_page_ack (.trn_clk, .reset_n, .strobe(page_return), .pulse(change_huge_page_ack));
    ack_stretch u_rd_ack   (.trn_clk, .reset_n, .strobe(rd_addr_strobe), .pulse(rd_addr_change));

    huge_page_slots u_slots (
        .trn_clk, .reset_n,
        .huge_page_addr_1, .huge_page_addr_2,
        .huge_page_status_1, .huge_page_status_2,
        .page_return, .page_available, .current_page_addr,
        .huge_page_free_1, .huge_page_free_2
    );

    tlp_tx_engine u_engine (
        .trn_clk, .reset_n,
        .req(req_s), .page_available, .current_page_addr,
        .trn_tdst_rdy_n, .trn_tbuf_av, .my_turn,
        .cfg_completer_id, .cfg_interrupt_rdy_n,
        .rd_data, .rd_addr, .commited_rd_address, .commited_rd_address_to_mac,
        .trn_tx, .cfg_interrupt_n, .driving_interface,
        .tlp_ack_strobe, .page_return, .rd_addr_strobe
    );

endmodule

// ==== bench/hugepage_tx_props.sv ====
//////////////////////////////////////////////////////////////////////
// TRN framing and interrupt handshake assertions, bound to the engine
//////////////////////////////////////////////////////////////////////

module hugepage_tx_props (
    input logic                     trn_clk,
    input logic                     reset_n,
    input hugepage_tx_pkg::trn_tx_t trn_tx,
    input logic                     trn_tdst_rdy_n,
    input logic                     cfg_interrupt_n,
    input logic                     cfg_interrupt_rdy_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // framing marks only ride on a valid beat
    a_frame_valid: assert property (@(posedge trn_clk) disable iff (!reset_n)
        trn_tx.tsrc_rdy_n |-> (trn_tx.tsof_n && trn_tx.teof_n))
        else $error("sof or eof low without tsrc_rdy_n");

    // a refused beat is held as it is
    a_beat_hold: assert property (@(posedge trn_clk) disable iff (!reset_n)
        (!trn_tx.tsrc_rdy_n && trn_tdst_rdy_n) |=> $stable(trn_tx))
        else $error("TRN outputs moved while the endpoint held a beat");

    // interrupt request held until the core answers
    a_irq_hold: assert property (@(posedge trn_clk) disable iff (!reset_n)
        (!cfg_interrupt_n && cfg_interrupt_rdy_n) |=> !cfg_interrupt_n)
        else $error("cfg_interrupt_n released before cfg_interrupt_rdy_n");

endmodule

bind tlp_tx_engine hugepage_tx_props u_props (
    .trn_clk(trn_clk), .reset_n(reset_n), .trn_tx(trn_tx), .trn_tdst_rdy_n(trn_tdst_rdy_n),
    .cfg_interrupt_n(cfg_interrupt_n), .cfg_interrupt_rdy_n(cfg_interrupt_rdy_n)
);

// ==== bench/hugepage_tx_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the hugepage transmit top: buffer and endpoint models,
// a table of data, close and turn tests, and a self-checking report
//////////////////////////////////////////////////////////////////////

module hugepage_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import hugepage_tx_pkg::*;

    localparam int NUM_TESTS   = 7;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT = 200 * NUM_TESTS + RESET_CYCLES;  // 200 cycles per row
    localparam int KIND_DATA = 0, KIND_CLOSE = 1, KIND_TURN = 2;
    localparam host_addr_t  PAGE_1 = 64'h0000_0012_3400_0000;
    localparam host_addr_t  PAGE_2 = 64'h0000_0056_7800_0000;
    localparam logic [15:0] COMPLETER_ID = 16'h0108;

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////
    string test_name [NUM_TESTS] = '{"data_q4", "data_q8_stall", "data_q1", "data_q16_stall",
                                     "close_page1", "turn_hold", "data_q5_stall"};
    int    test_kind [NUM_TESTS] = '{KIND_DATA, KIND_DATA, KIND_DATA, KIND_DATA,
                                     KIND_CLOSE, KIND_TURN, KIND_DATA};
    int    test_qw   [NUM_TESTS] = '{4, 8, 1, 16, 0, 6, 5};
    bit    test_stall[NUM_TESTS] = '{0, 1, 0, 1, 0, 0, 1};
    int    test_tag  [NUM_TESTS] = '{0, 1, 2, 3, 0, 4, 5};

    logic trn_clk = 1'b0, reset_n, cfg_interrupt_n, cfg_interrupt_rdy_n, my_turn;
    logic trn_tdst_rdy_n = 1'b0;                        // endpoint ready, active low
    logic [3:0] trn_tbuf_av;
    logic [15:0] cfg_completer_id;
    trn_tx_t trn_tx;
    host_addr_t huge_page_addr_1, huge_page_addr_2;
    logic huge_page_status_1, huge_page_status_2, huge_page_free_1, huge_page_free_2;
    tx_req_t req_raw;
    logic trigger_tlp_ack, change_huge_page_ack, rd_addr_change, driving_interface;
    buf_rd_addr_t rd_addr, rd_addr_q = '0;
    logic [63:0] rd_data = '0;
    buf_addr_t commited_rd_address, commited_rd_address_to_mac;

    logic [63:0] beat_td[$];                            // accepted beats of the running test
    logic beat_sof[$], beat_eof[$], eof_seen = 1'b0, stall_en = 1'b0;
    int tlp_ack_cycles, page_ack_cycles, free1_cnt, free2_cnt, drive_cycles;
    int seed = 36, cycle_cnt = 0, errors = 0, checks = 0, exp_rd_ptr = 0, page_sel = 0;
    host_addr_t exp_host_addr = PAGE_1 + 64'd128;
    logic [31:0] exp_page_cnt = '0;

    hugepage_tx_top u_dut (.*);

    always #5 trn_clk = ~trn_clk;                       // 10 ns period

    // buffer model, word is a fixed function of its address
    function automatic logic [63:0] buf_word(input logic [8:0] a);
        return {7'h2d, a, 7'h4b, ~a, 16'hbeef, 7'h00, a};
    endfunction

    function automatic logic [63:0] rev_bytes64(input logic [63:0] x);
        return {x[7:0], x[15:8], x[23:16], x[31:24], x[39:32], x[47:40], x[55:48], x[63:56]};
    endfunction

    function automatic logic [63:0] expected_hdr(input logic [9:0] len, input logic [3:0] tag);
        return {1'b0, MEM_WR64_FMT_TYPE, 14'h0, len, COMPLETER_ID, 4'h0, tag, 8'hff};
    endfunction

    always @(posedge trn_clk) rd_addr_q <= rd_addr;     // one cycle read latency
    always @(negedge trn_clk) begin
        rd_data = buf_word(rd_addr_q);
        trn_tdst_rdy_n = stall_en ? (($random(seed) & 3) == 0) : 1'b0;  // random back-pressure
    end

    // endpoint monitor, records what the link really took
    always @(posedge trn_clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("run timed out waiting for a TLP after %0d cycles", cycle_cnt);
            $display("Errors found");
            $finish;
        end
        if (reset_n) begin
            if (!trn_tx.tsrc_rdy_n && !trn_tdst_rdy_n) begin
                beat_td.push_back(trn_tx.td);
                beat_sof.push_back(trn_tx.tsof_n);
                beat_eof.push_back(trn_tx.teof_n);
                if (!trn_tx.teof_n) eof_seen = 1'b1;
            end
            tlp_ack_cycles  += trigger_tlp_ack;
            page_ack_cycles += change_huge_page_ack;
            free1_cnt       += huge_page_free_1;
            free2_cnt       += huge_page_free_2;
            drive_cycles    += driving_interface;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic clear_monitor();
        beat_td.delete();
        beat_sof.delete();
        beat_eof.delete();
        eof_seen = 1'b0;
        {tlp_ack_cycles, page_ack_cycles, free1_cnt, free2_cnt, drive_cycles} = '0;
    endtask

    task automatic wait_sof();                          // drop the request once the TLP is up
        while (trn_tx.tsof_n || trn_tx.tsrc_rdy_n) @(negedge trn_clk);
    endtask

    task automatic wait_eof();
        while (!eof_seen) @(negedge trn_clk);
    endtask

    task automatic check_framing(input string name, input int n);
        for (int i = 0; i < n; i++) begin
            check_value({name, " sof"}, (i == 0) ? 1'b0 : 1'b1, beat_sof[i]);
            check_value({name, " eof"}, (i == n - 1) ? 1'b0 : 1'b1, beat_eof[i]);
        end
    endtask

    task automatic send_data(input int idx, input bit hold_turn);
        int q;
        q = test_qw[idx];
        clear_monitor();
        req_raw.qwords_to_send = qword_cnt_t'(q);
        req_raw.trigger_tlp = 1'b1;
        if (hold_turn) begin                            // no beat while another owner drives
            my_turn = 1'b0;
            repeat (20) @(negedge trn_clk);
            check_value({test_name[idx], " held beats"}, 0, beat_td.size());
            check_value({test_name[idx], " held drive"}, 0, drive_cycles);
            my_turn = 1'b1;
        end
        stall_en = test_stall[idx];
        wait_sof();
        req_raw.trigger_tlp = 1'b0;
        wait_eof();
        stall_en = 1'b0;
        repeat (6) @(negedge trn_clk);
        check_value({test_name[idx], " beats"}, q + 2, beat_td.size());
        if (beat_td.size() == q + 2) begin
            check_value({test_name[idx], " header"}, expected_hdr(10'(2 * q),
                        4'(test_tag[idx])), beat_td[0]);
            check_value({test_name[idx], " address"}, exp_host_addr, beat_td[1]);
            for (int i = 0; i < q; i++) begin
                check_value({test_name[idx], " payload"},
                            rev_bytes64(buf_word(9'(exp_rd_ptr + i))), beat_td[i + 2]);
            end
            check_framing(test_name[idx], q + 2);
        end
        check_value({test_name[idx], " ack cycles"}, 3, tlp_ack_cycles);
        check_value({test_name[idx], " commit"}, buf_addr_t'(exp_rd_ptr + q),
                    commited_rd_address);                 // buffer words consumed so far
        check_value({test_name[idx], " commit to mac"}, buf_addr_t'(exp_rd_ptr + q),
                    commited_rd_address_to_mac);
        exp_host_addr += 64'(8 * q);                    // next TLP lands right after
        exp_page_cnt  += 32'(q);
        exp_rd_ptr    += q;
    endtask

    task automatic close_page(input int idx);
        host_addr_t base;
        base = page_sel ? PAGE_2 : PAGE_1;
        clear_monitor();
        req_raw.change_huge_page = 1'b1;
        wait_sof();
        req_raw.change_huge_page = 1'b0;
        wait_eof();
        while (cfg_interrupt_n) @(negedge trn_clk);
        repeat (3) begin                                // must hold until core answers
            @(negedge trn_clk);
            check_value({test_name[idx], " irq held"}, 1'b0, cfg_interrupt_n);
        end
        cfg_interrupt_rdy_n = 1'b0;
        @(negedge trn_clk);
        cfg_interrupt_rdy_n = 1'b1;
        check_value({test_name[idx], " irq release"}, 1'b1, cfg_interrupt_n);
        repeat (4) @(negedge trn_clk);
        check_value({test_name[idx], " beats"}, 3, beat_td.size());
        if (beat_td.size() == 3) begin
            check_value({test_name[idx], " header"}, expected_hdr(10'd2, 4'h0), beat_td[0]);
            check_value({test_name[idx], " address"}, base, beat_td[1]);
            check_value({test_name[idx], " count"},
                        {exp_page_cnt[7:0], exp_page_cnt[15:8], exp_page_cnt[23:16],
                         exp_page_cnt[31:24], 32'h0}, beat_td[2]);
            check_framing(test_name[idx], 3);
        end
        check_value({test_name[idx], " free 1"}, page_sel ? 0 : 1, free1_cnt);
        check_value({test_name[idx], " free 2"}, page_sel ? 1 : 0, free2_cnt);
        check_value({test_name[idx], " page ack"}, 3, page_ack_cycles);
        page_sel      = 1 - page_sel;
        exp_host_addr = (page_sel ? PAGE_2 : PAGE_1) + 64'd128;
        exp_page_cnt  = '0;
    endtask

    initial begin
        reset_n = 1'b0;
        trn_tbuf_av = 4'hf;
        cfg_completer_id = COMPLETER_ID;
        cfg_interrupt_rdy_n = 1'b1;
        my_turn = 1'b1;
        huge_page_addr_1 = PAGE_1;
        huge_page_addr_2 = PAGE_2;
        huge_page_status_1 = 1'b1;                      // both pages ready from the start
        huge_page_status_2 = 1'b1;
        req_raw = '0;
        repeat (RESET_CYCLES) @(negedge trn_clk);
        check_value("reset strobes", 3'b111, {trn_tx.tsof_n, trn_tx.teof_n, trn_tx.tsrc_rdy_n});
        check_value("reset trem_n", 8'hff, trn_tx.trem_n);
        check_value("reset irq", 1'b1, cfg_interrupt_n);
        check_value("reset outputs", 6'b0, {trigger_tlp_ack, change_huge_page_ack,
                    rd_addr_change, huge_page_free_1, huge_page_free_2, driving_interface});
        $display("test reset_values finished, %0d errors so far", errors);
        reset_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            case (test_kind[i])
                KIND_CLOSE: close_page(i);
                KIND_TURN:  send_data(i, 1'b1);
                default:    send_data(i, 1'b0);
            endcase
            $display("test %s finished, %0d errors so far", test_name[i], errors);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/hugepage_tx_pkg.sv
verilog/req_sync.sv
verilog/ack_stretch.sv
verilog/huge_page_slots.sv
verilog/tlp_tx_engine.sv
verilog/hugepage_tx_top.sv
bench/hugepage_tx_props.sv
bench/hugepage_tx_tb.sv
